/* vlog.f */
+incdir+hdl
hdl/gamePkg.sv
hdl/pointMover.sv
hdl/backgroundStore.sv
hdl/gameJudge.sv
hdl/matrixScan.sv
hdl/gameTop.sv
verif/gameTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the game core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module gameTb -f vlog.f > build.log 2>&1 \
	&& ./obj_dir/VgameTb > sim.log 2>&1 ; cat sim.log 2>/dev/null
grep -qx "No errors" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* verif/gameTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_config.svh"

module gameTb;

	localparam int NumRounds = 5;
	localparam int SpawnCol = 4;
	localparam int TimeoutCycles = NumRounds * `MATRIX_SIZE * `FALL_PERIOD + 200;

	// Start and end frames with the top row first
	localparam gamePkg::frameT StartFrame = {
		8'b00010000, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'b11011111, 8'b11010111
	};
	localparam gamePkg::frameT FaceLose = {
		8'b00000000, 8'b00100100, 8'b00100100, 8'b00100100,
		8'b00000000, 8'b00111100, 8'b01000010, 8'b00000000
	};
	localparam gamePkg::frameT FaceWin = {
		8'b00000000, 8'b00100100, 8'b00100100, 8'b00100100,
		8'b00000000, 8'b01000010, 8'b00111100, 8'b00000000
	};

	logic clock50;
	logic arstN;
	logic startButton;
	logic leftButton;
	logic rightButton;
	gamePkg::posT scanAddr;
	wire gamePkg::frameT frame;
	wire gamePkg::gameStateT gameState;
	wire gamePkg::rowT scanData;
	int cycleCount = 0;

	// ##########################################################
	// Round table with lefts issued before rights
	// ##########################################################
	string testName [NumRounds] = '{
		"rightSaturate", "noSteer", "leftToGap", "leftRightGap", "leftSaturate"
	};
	int leftCount [NumRounds] = '{0, 0, 1, 2, 5};
	int rightCount [NumRounds] = '{6, 0, 0, 1, 0};
	gamePkg::gameStateT expState [NumRounds] = '{
		gamePkg::stLose, gamePkg::stLose, gamePkg::stWin, gamePkg::stWin, gamePkg::stLose
	};
	gamePkg::frameT expFrame [NumRounds] = '{FaceLose, FaceLose, FaceWin, FaceWin, FaceLose};

	gameTop UUT (
		.clock50(clock50),
		.arstN(arstN),
		.startButton(startButton),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.scanAddr(scanAddr),
		.frame(frame),
		.gameState(gameState),
		.scanData(scanData)
	);

	initial begin
		clock50 = 1'b0;
		forever #2 clock50 = ~clock50;
	end

	// Run limit
	always @(posedge clock50) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout after %0d cycles, a round never came to an end", cycleCount);
			$display("Errors found");
			$fatal(1, "Simulation timed out");
		end
	end

	// ##########################################################
	// Checks and helpers
	// ##########################################################
	task automatic checkValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Column after steering with saturation at both edges
	function automatic gamePkg::posT expectedColumn(input int nLeft, input int nRight);
		int col;
		col = SpawnCol;
		for (int k = 0; k < nLeft; k++) begin
			if (col < 7)
				col++;
		end
		for (int k = 0; k < nRight; k++) begin
			if (col > 0)
				col--;
		end
		return gamePkg::posT'(col);
	endfunction

	// Column 7 minus addr of a frame with row 0 in the MSB
	function automatic gamePkg::rowT scanColumn(input gamePkg::frameT f, input gamePkg::posT addr);
		gamePkg::rowT col;
		for (int r = 0; r < 8; r++) begin
			col[7 - r] = f[r][7 - int'(addr)];
		end
		return col;
	endfunction

	task automatic startRound(input int idx);
		gamePkg::posT spawnAddr;
		spawnAddr = gamePkg::posT'(7 - SpawnCol);
		@(posedge clock50);
		startButton <= 1'b1;
		@(posedge clock50);
		startButton <= 1'b0;
		// Spawn column differs from its mirror column in the start frame
		scanAddr <= spawnAddr;
		@(posedge clock50);
		@(negedge clock50);
		checkValue($sformatf("%s start state", testName[idx]),
			64'(gamePkg::stPlay), 64'(gameState));
		checkValue($sformatf("%s start row 7", testName[idx]), 64'(8'b00010000), 64'(frame[7]));
		checkValue($sformatf("%s start row 1", testName[idx]), 64'(8'b11011111), 64'(frame[1]));
		checkValue($sformatf("%s start row 0", testName[idx]), 64'(8'b11010111), 64'(frame[0]));
		checkValue($sformatf("%s start scan", testName[idx]),
			64'(scanColumn(StartFrame, spawnAddr)), 64'(scanData));
	endtask

	task automatic pulseButton(input bit goLeft);
		@(posedge clock50);
		if (goLeft)
			leftButton <= 1'b1;
		else
			rightButton <= 1'b1;
		@(posedge clock50);
		leftButton <= 1'b0;
		rightButton <= 1'b0;
	endtask

	task automatic scanCheck(input int idx);
		gamePkg::posT addr;
		for (int k = 0; k < 8; k++) begin
			addr = gamePkg::posT'($urandom());
			@(posedge clock50);
			scanAddr <= addr;
			@(negedge clock50);
			checkValue($sformatf("%s scan column %0d", testName[idx], addr),
				64'(scanColumn(expFrame[idx], addr)), 64'(scanData));
		end
	endtask

	// ##########################################################
	// Main sequence
	// ##########################################################
	initial begin
		gamePkg::posT col;
		arstN = 1'b0;
		startButton = 1'b0;
		leftButton = 1'b0;
		rightButton = 1'b0;
		scanAddr = '0;
		void'($urandom(32'hd1d7955e));
		repeat (5) @(posedge clock50);
		arstN <= 1'b1;
		@(negedge clock50);
		checkValue("reset state", 64'(gamePkg::stIdle), 64'(gameState));
		checkValue("reset frame", 64'(0), frame);

		for (int i = 0; i < NumRounds; i++) begin
			startRound(i);
			for (int k = 0; k < leftCount[i]; k++)
				pulseButton(1'b1);
			for (int k = 0; k < rightCount[i]; k++)
				pulseButton(1'b0);
			// Point is still in row 7 before the first drop
			@(negedge clock50);
			col = expectedColumn(leftCount[i], rightCount[i]);
			checkValue($sformatf("%s steered row 7", testName[i]),
				64'(gamePkg::rowT'(1) << col), 64'(frame[7]));
			while (gameState == gamePkg::stPlay)
				@(negedge clock50);
			// Face arrives one cycle after the state change
			@(negedge clock50);
			checkValue($sformatf("%s end state", testName[i]), 64'(expState[i]), 64'(gameState));
			for (int r = 0; r < 8; r++) begin
				checkValue($sformatf("%s end row %0d", testName[i], r),
					64'(expFrame[i][r]), 64'(frame[r]));
			end
			scanCheck(i);
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/gameTop.sv */
`timescale 1ns/100ps
`default_nettype none

module gameTop (
	input wire clock50,
	input wire arstN,
	input wire startButton,
	input wire leftButton,
	input wire rightButton,
	input wire gamePkg::posT scanAddr,
	output wire gamePkg::frameT frame,
	output wire gamePkg::gameStateT gameState,
	output wire gamePkg::rowT scanData
);

	wire newRound;
	wire gamePkg::posT pointRow;
	wire gamePkg::posT pointCol;
	wire gamePkg::frameT backgRows;

	// ##########################################################
	// Falling point and background, loaded side by side
	// ##########################################################
	pointMover pointMoverU0 (
		.clock50(clock50),
		.arstN(arstN),
		.newRound(newRound),
		.gameState(gameState),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.pointRow(pointRow),
		.pointCol(pointCol)
	);

	backgroundStore backgroundStoreU0 (
		.clock50(clock50),
		.arstN(arstN),
		.newRound(newRound),
		.gameState(gameState),
		.backgRows(backgRows)
	);

	// ##########################################################
	// Judge and display path
	// ##########################################################
	gameJudge gameJudgeU0 (
		.clock50(clock50),
		.arstN(arstN),
		.startButton(startButton),
		.pointRow(pointRow),
		.pointCol(pointCol),
		.backgRows(backgRows),
		.newRound(newRound),
		.gameState(gameState),
		.frame(frame)
	);

	matrixScan matrixScanU0 (
		.frame(frame),
		.scanAddr(scanAddr),
		.scanData(scanData)
	);

endmodule

`default_nettype wire

/* hdl/matrixScan.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_config.svh"

module matrixScan (
	input wire gamePkg::frameT frame,
	input wire gamePkg::posT scanAddr,
	output gamePkg::rowT scanData
);

	gamePkg::posT scanCol;

	// Address 0 selects the leftmost column
	assign scanCol = gamePkg::posT'(`MATRIX_SIZE - 1) - scanAddr;

	// Row 0 goes out in the MSB, as the display driver expects
	always_comb begin
		for (int r = 0; r < `MATRIX_SIZE; r++) begin
			scanData[`MATRIX_SIZE - 1 - r] = frame[r][scanCol];
		end
	end

endmodule

`default_nettype wire

/* hdl/gameJudge.sv */
`timescale 1ns/100ps
`default_nettype none

module gameJudge (
	input wire clock50,
	input wire arstN,
	input wire startButton,
	input wire gamePkg::posT pointRow,
	input wire gamePkg::posT pointCol,
	input wire gamePkg::frameT backgRows,
	output logic newRound,
	output gamePkg::gameStateT gameState,
	output gamePkg::frameT frame
);

	logic hit;
	logic bottom;
	gamePkg::frameT pointMask;

	// Point sits on a set background cell
	assign hit = backgRows[pointRow][pointCol];
	assign bottom = (pointRow == '0);

	// ##########################################################
	// Game state machine
	// ##########################################################
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			gameState <= gamePkg::stIdle;
			newRound <= 1'b0;
		end else begin
			newRound <= 1'b0;
			case (gameState)
				gamePkg::stPlay: begin
					// Position is stale while the load pulse is high
					if (!newRound) begin
						if (hit)
							gameState <= gamePkg::stLose;
						else if (bottom)
							gameState <= gamePkg::stWin;
					end
				end
				default: begin
					// Idle, win and lose all accept a new start
					if (startButton) begin
						gameState <= gamePkg::stPlay;
						newRound <= 1'b1;
					end
				end
			endcase
		end
	end

	// ##########################################################
	// Merged frame
	// ##########################################################
	always_comb begin
		pointMask = '0;
		pointMask[pointRow][pointCol] = 1'b1;
	end

	always_comb begin
		case (gameState)
			gamePkg::stIdle: frame = '0;
			gamePkg::stPlay: frame = backgRows | pointMask;
			default: frame = backgRows;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/backgroundStore.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_config.svh"

module backgroundStore (
	input wire clock50,
	input wire arstN,
	input wire newRound,
	input wire gamePkg::gameStateT gameState,
	output gamePkg::frameT backgRows
);

	// Fixed pictures, top row first
	localparam gamePkg::frameT StartPattern = {
		{(`MATRIX_SIZE - 2){8'h00}},
		`BACKG_ROW1,
		`BACKG_ROW0
	};

	localparam gamePkg::frameT FaceLose = {
		`FACE_LOSE_7, `FACE_LOSE_6, `FACE_LOSE_5, `FACE_LOSE_4,
		`FACE_LOSE_3, `FACE_LOSE_2, `FACE_LOSE_1, `FACE_LOSE_0
	};

	localparam gamePkg::frameT FaceWin = {
		`FACE_WIN_7, `FACE_WIN_6, `FACE_WIN_5, `FACE_WIN_4,
		`FACE_WIN_3, `FACE_WIN_2, `FACE_WIN_1, `FACE_WIN_0
	};

	// ##########################################################
	// Background rows
	// ##########################################################
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			backgRows <= '0;
		end else if (newRound) begin
			backgRows <= StartPattern;
		end else begin
			// Face follows the end state by one cycle, held until next round
			case (gameState)
				gamePkg::stLose: backgRows <= FaceLose;
				gamePkg::stWin: backgRows <= FaceWin;
				default: backgRows <= backgRows;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/pointMover.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_config.svh"

module pointMover (
	input wire clock50,
	input wire arstN,
	input wire newRound,
	input wire gamePkg::gameStateT gameState,
	input wire leftButton,
	input wire rightButton,
	output gamePkg::posT pointRow,
	output gamePkg::posT pointCol
);

	localparam int CntWidth = $clog2(`FALL_PERIOD);
	localparam gamePkg::posT EdgeLeft = gamePkg::posT'(`MATRIX_SIZE - 1);
	localparam gamePkg::posT EdgeRight = '0;

	logic [CntWidth-1:0] fallCnt;
	logic fallTick;
	logic inPlay;

	assign inPlay = (gameState == gamePkg::stPlay);
	assign fallTick = (fallCnt == CntWidth'(`FALL_PERIOD - 1));

	// ##########################################################
	// Fall timer
	// ##########################################################
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			fallCnt <= '0;
		end else if (newRound || fallTick) begin
			// Restart on a new round and after every drop
			fallCnt <= '0;
		end else if (inPlay) begin
			fallCnt <= fallCnt + 1'b1;
		end
	end

	// ##########################################################
	// Row, falls towards row 0
	// ##########################################################
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			pointRow <= `START_ROW;
		end else if (newRound) begin
			pointRow <= `START_ROW;
		end else if (inPlay && fallTick && pointRow != '0) begin
			pointRow <= pointRow - 1'b1;
		end
	end

	// ##########################################################
	// Column, left raises the index
	// ##########################################################
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			pointCol <= `START_COL;
		end else if (newRound) begin
			pointCol <= `START_COL;
		end else if (inPlay) begin
			if (leftButton && !rightButton) begin
				if (pointCol != EdgeLeft)
					pointCol <= pointCol + 1'b1;
			end else if (rightButton && !leftButton) begin
				if (pointCol != EdgeRight)
					pointCol <= pointCol - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/gamePkg.sv */
`default_nettype none

`include "game_config.svh"

package gamePkg;

	// One matrix row, bit 7 is the leftmost column
	typedef logic [`MATRIX_SIZE-1:0] rowT;

	// Whole picture, index 7 is the top row
	typedef rowT [`MATRIX_SIZE-1:0] frameT;

	// Row or column index
	typedef logic [`POS_WIDTH-1:0] posT;

	// Round progress
	typedef enum logic [1:0] {
		stIdle,
		stPlay,
		stWin,
		stLose
	} gameStateT;

endpackage

`default_nettype wire

/* hdl/game_config.svh */
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// Matrix geometry
`define MATRIX_SIZE 8
`define POS_WIDTH 3

// Clock cycles between two drops of the point
`define FALL_PERIOD 16

// Spawn position, top row
`define START_ROW 3'd7
`define START_COL 3'd4

// Start background, column 5 is the gap
`define BACKG_ROW1 8'b11011111
`define BACKG_ROW0 8'b11010111

// Frowning face
`define FACE_LOSE_7 8'b00000000
`define FACE_LOSE_6 8'b00100100
`define FACE_LOSE_5 8'b00100100
`define FACE_LOSE_4 8'b00100100
`define FACE_LOSE_3 8'b00000000
`define FACE_LOSE_2 8'b00111100
`define FACE_LOSE_1 8'b01000010
`define FACE_LOSE_0 8'b00000000

// Smiling face
`define FACE_WIN_7 8'b00000000
`define FACE_WIN_6 8'b00100100
`define FACE_WIN_5 8'b00100100
`define FACE_WIN_4 8'b00100100
`define FACE_WIN_3 8'b00000000
`define FACE_WIN_2 8'b01000010
`define FACE_WIN_1 8'b00111100
`define FACE_WIN_0 8'b00000000

`endif
